// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP        = tb_mem_subsys
RTL_TOP    = mem_subsys
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/lsu_pkg.sv
package lsu_pkg;

    // access width, matches the core's size field
    typedef enum logic [1:0] {
        size_none = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } access_size_t;

    // core-local timer window, mtime low word at base, high word at base + 4
    localparam logic [31:0] CLINT_BASE = 32'h0200_0048;
    localparam logic [31:0] CLINT_END  = 32'h0200_004f;

    // main memory
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam int          SRAM_WORDS = 256;
    localparam int          SRAM_AW    = $clog2(SRAM_WORDS);

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: compile.f
common/lsu_pkg.sv
lsu/lsu_align.sv
lsu/lsu.sv
logic/clint.sv
logic/axi_sram.sv
logic/mem_subsys.sv
dv/clk_gen.sv
dv/tb_mem_subsys.sv

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over the first cycles, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: dv/lsu_input.txt
# op size sign addr wdata exp_rdata exp_err check
# op ld or st, size b h w, check none data mark increasing (hex for addr and data)
st w 0 80000000 11223344 00000000 0 none
st w 0 80000004 a5a5a5a5 00000000 0 none
st w 0 800003fc deadbeef 00000000 0 none
ld w 0 80000000 00000000 11223344 0 data
ld w 0 80000004 00000000 a5a5a5a5 0 data
ld w 0 800003fc 00000000 deadbeef 0 data
st w 0 80000010 00000000 00000000 0 none
st b 0 80000011 ffffffab 00000000 0 none
st b 0 80000013 ffffff12 00000000 0 none
ld w 0 80000010 00000000 1200ab00 0 data
st b 0 80000010 00000034 00000000 0 none
st b 0 80000012 00000056 00000000 0 none
ld w 0 80000010 00000000 1256ab34 0 data
st w 0 80000014 ffffffff 00000000 0 none
st h 0 80000014 abcd1234 00000000 0 none
st h 0 80000016 00005678 00000000 0 none
ld w 0 80000014 00000000 56781234 0 data
ld b 1 800003fc 00000000 ffffffef 0 data
ld b 0 800003fc 00000000 000000ef 0 data
ld b 1 800003fd 00000000 ffffffbe 0 data
ld b 0 800003fe 00000000 000000ad 0 data
ld b 1 80000001 00000000 00000033 0 data
ld h 1 800003fc 00000000 ffffbeef 0 data
ld h 0 800003fe 00000000 0000dead 0 data
ld h 1 80000016 00000000 00005678 0 data
ld h 1 80000006 00000000 ffffa5a5 0 data
st w 0 80000400 cafef00d 00000000 1 none
ld w 0 80000400 00000000 00000000 1 data
ld w 0 10000000 00000000 00000000 1 data
ld w 0 80000000 00000000 11223344 0 data
ld w 0 02000048 00000000 00000000 0 mark
ld w 0 02000048 00000000 00000000 0 increasing
st w 0 02000048 00000001 00000000 1 none
ld w 0 0200004c 00000000 00000000 0 data

// File: dv/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import lsu_pkg::*; ();

    localparam int RESET_TIMEOUT = 50;
    localparam int READY_TIMEOUT = 200;
    localparam int DONE_TIMEOUT  = 200;

    logic         clk;
    logic         reset;
    logic         req;
    logic         wen;
    access_size_t size;
    logic         sign;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic         ready;
    logic         done;
    logic [31:0]  rdata;
    logic         err;

    logic [31:0]  lcg_state;
    logic [31:0]  mark_value;
    int           n_access;

    clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    mem_subsys u_mem_subsys (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .wen   (wen),
        .size  (size),
        .sign  (sign),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .done  (done),
        .rdata (rdata),
        .err   (err)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // size letter from the input file
    function automatic access_size_t size_from_code(input logic [7:0] c);
        case (c)
            "b":     return size_byte;
            "h":     return size_half;
            "w":     return size_word;
            default: return size_none;
        endcase
    endfunction

    task automatic stop_on_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "wrong value from the DUT");
    endtask

    task automatic stop_on_fault(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s rdata %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s err %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_handshake(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_greater(input logic [31:0] got, input logic [31:0] floor,
                                 input string what);
        if (!(got > floor)) begin
            stop_on_mismatch($sformatf("%s rdata %h, not above %h", what, got, floor));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset) begin
            if (cycles >= RESET_TIMEOUT) begin
                stop_on_fault("reset was never released");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready) begin
            if (cycles >= READY_TIMEOUT) begin
                stop_on_fault("the lsu never became ready for a request");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // one request, held for a single cycle, then wait for done
    task automatic run_access(input logic wr, input access_size_t sz, input logic sg,
                              input logic [31:0] a, input logic [31:0] d);
        int cycles;
        wait_ready();
        @(posedge clk);
        req   <= 1'b1;
        wen   <= wr;
        size  <= sz;
        sign  <= sg;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        // request taken, so the lsu is busy now
        check_handshake(ready, 1'b0, $sformatf("ready after the request at %h", a));
        while (!done) begin
            if (cycles >= DONE_TIMEOUT) begin
                stop_on_fault($sformatf("no done for the access at address %h", a));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        check_handshake(ready, 1'b1, $sformatf("ready with done at %h", a));
        // done is a single-cycle pulse
        @(negedge clk);
        check_handshake(done, 1'b0, $sformatf("done a cycle after done at %h", a));
    endtask

    initial begin
        int             fd;
        int             code;
        int             sign_in;
        int             exp_err;
        string          line;
        string          what;
        logic [8*8-1:0] op_code;
        logic [7:0]     size_code;
        logic [31:0]    addr_in;
        logic [31:0]    wdata_in;
        logic [31:0]    exp_rdata;
        logic [8*12-1:0] kind;

        req        = 1'b0;
        wen        = 1'b0;
        size       = size_none;
        sign       = 1'b0;
        addr       = 32'h0;
        wdata      = 32'h0;
        lcg_state  = 32'h2785;
        mark_value = 32'h0;
        n_access   = 0;

        fd = $fopen("dv/lsu_input.txt", "r");
        if (fd == 0) begin
            stop_on_fault("cannot open dv/lsu_input.txt");
        end
        wait_reset_release();

        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%s %s %d %h %h %h %d %s", op_code, size_code,
                               sign_in, addr_in, wdata_in, exp_rdata, exp_err, kind);
                if (code != 8) begin
                    stop_on_fault($sformatf("malformed input line: %s", line));
                end
                // idle gap of 0 to 3 cycles between requests
                lcg_state = lcg_next(lcg_state);
                repeat (lcg_state[17:16]) @(posedge clk);

                run_access(op_code == "st", size_from_code(size_code), sign_in[0],
                           addr_in, wdata_in);
                what = $sformatf("access %0d at %h", n_access, addr_in);
                check_err(err, exp_err[0], what);
                if (kind == "data") begin
                    check_data(rdata, exp_rdata, what);
                end else if (kind == "mark") begin
                    mark_value = rdata;
                end else if (kind == "increasing") begin
                    check_greater(rdata, mark_value, what);
                end else if (kind != "none") begin
                    stop_on_fault($sformatf("unknown check kind in input line: %s", line));
                end
                n_access++;
            end
        end
        $fclose(fd);

        if (n_access == 0) begin
            stop_on_fault("the input file held no accesses");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: logic/axi_sram.sv
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic [2:0]  awsize,

    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,

    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,

    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [2:0]  arsize,

    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast
);

    typedef enum logic [1:0] {
        s_idle,
        s_wdata,
        s_bresp,
        s_rresp
    } state_t;

    state_t state;

    logic [31:0]        mem [SRAM_WORDS];
    logic [SRAM_AW-1:0] wr_index;
    logic               wr_bad;
    logic [31:0]        aw_off;
    logic [31:0]        ar_off;
    logic               aw_hs;
    logic               w_hs;
    logic               ar_hs;
    logic               ar_ok;
    logic               w_commit;

    // inside memory and no wider than the bus
    function automatic logic addr_ok(input logic [31:0] a, input logic [2:0] sz);
        logic [31:0] off;
        off = a - SRAM_BASE;
        return (a >= SRAM_BASE) && (off < 32'(SRAM_WORDS * 4)) && (sz <= 3'd2);
    endfunction

    assign aw_off = awaddr - SRAM_BASE;
    assign ar_off = araddr - SRAM_BASE;
    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign ar_hs  = arvalid && arready && !aw_hs;
    assign ar_ok  = addr_ok(araddr, arsize);

    // only a well-formed last beat to a valid word touches memory
    assign w_commit = w_hs && !wr_bad && wlast;

    assign rlast = rvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            awready <= 1'b0;
            arready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (aw_hs) begin
                        awready <= 1'b0;
                        arready <= 1'b0;
                        wready  <= 1'b1;
                        state   <= s_wdata;
                    end else if (ar_hs) begin
                        awready <= 1'b0;
                        arready <= 1'b0;
                        rvalid  <= 1'b1;
                        state   <= s_rresp;
                    end else begin
                        awready <= 1'b1;
                        arready <= 1'b1;
                    end
                end
                s_wdata: begin
                    if (w_hs) begin
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= s_bresp;
                    end
                end
                s_bresp: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= s_idle;
                    end
                end
                s_rresp: begin
                    if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state  <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_index <= aw_off[SRAM_AW+1:2];
            wr_bad   <= !addr_ok(awaddr, awsize);
        end
        if (w_hs) begin
            bresp <= w_commit ? RESP_OKAY : RESP_SLVERR;
        end
        if (ar_hs) begin
            rdata <= ar_ok ? mem[ar_off[SRAM_AW+1:2]] : 32'h0;
            rresp <= ar_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // byte-strobed write
    always_ff @(posedge clk) begin
        if (w_commit) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[wr_index][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: logic/clint.sv
`timescale 1ns/1ps

module clint import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    input  logic        rready,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    logic [63:0] mtime;
    logic [31:0] offset;
    logic        ar_hs;

    assign offset  = araddr - CLINT_BASE;
    assign arready = !rvalid;
    assign ar_hs   = arvalid && arready;
    assign rresp   = RESP_OKAY;

    // free-running machine timer
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime  <= 64'h0;
            rvalid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // bit 2 of the window offset picks the high word
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= offset[2] ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// File: logic/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         req,
    input  logic         wen,
    input  access_size_t size,
    input  logic         sign,
    input  logic [31:0]  addr,
    input  logic [31:0]  wdata,
    output logic         ready,
    output logic         done,
    output logic [31:0]  rdata,
    output logic         err
);

    // lsu to sram
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic [2:0]  awsize;
    logic        wvalid;
    logic        wready;
    logic [31:0] bus_wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arsize;
    logic        rvalid;
    logic        rready;
    logic [31:0] bus_rdata;
    logic [1:0]  rresp;
    logic        rlast;

    // lsu to timer
    logic        t_arvalid;
    logic        t_arready;
    logic [31:0] t_araddr;
    logic        t_rvalid;
    logic [31:0] t_rdata;
    logic [1:0]  t_rresp;

    lsu u_lsu (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .wen       (wen),
        .size      (size),
        .sign      (sign),
        .addr      (addr),
        .wdata     (wdata),
        .ready     (ready),
        .done      (done),
        .rdata     (rdata),
        .err       (err),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awsize    (awsize),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata_o   (bus_wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arsize    (arsize),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata_i   (bus_rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .t_arvalid (t_arvalid),
        .t_arready (t_arready),
        .t_araddr  (t_araddr),
        .t_rvalid  (t_rvalid),
        .t_rdata   (t_rdata),
        .t_rresp   (t_rresp)
    );

    // lsu always takes the timer response at once
    clint u_clint (
        .clk     (clk),
        .reset   (reset),
        .arvalid (t_arvalid),
        .araddr  (t_araddr),
        .rready  (1'b1),
        .arready (t_arready),
        .rvalid  (t_rvalid),
        .rdata   (t_rdata),
        .rresp   (t_rresp)
    );

    axi_sram u_axi_sram (
        .clk     (clk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awsize  (awsize),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (bus_wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arsize  (arsize),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (bus_rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

endmodule

// File: lsu/lsu.sv
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // core side
    input  logic         req,
    input  logic         wen,
    input  access_size_t size,
    input  logic         sign,
    input  logic [31:0]  addr,
    input  logic [31:0]  wdata,
    output logic         ready,
    output logic         done,
    output logic [31:0]  rdata,
    output logic         err,

    // axi master
    output logic         awvalid,
    input  logic         awready,
    output logic [31:0]  awaddr,
    output logic [2:0]   awsize,
    output logic         wvalid,
    input  logic         wready,
    output logic [31:0]  wdata_o,
    output logic [3:0]   wstrb,
    output logic         wlast,
    input  logic         bvalid,
    output logic         bready,
    input  logic [1:0]   bresp,
    output logic         arvalid,
    input  logic         arready,
    output logic [31:0]  araddr,
    output logic [2:0]   arsize,
    input  logic         rvalid,
    output logic         rready,
    input  logic [31:0]  rdata_i,
    input  logic [1:0]   rresp,
    input  logic         rlast,

    // timer read port
    output logic         t_arvalid,
    input  logic         t_arready,
    output logic [31:0]  t_araddr,
    input  logic         t_rvalid,
    input  logic [31:0]  t_rdata,
    input  logic [1:0]   t_rresp
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp,
        st_done
    } state_t;

    state_t state;
    state_t state_next;

    // captured request
    logic         wen_q;
    access_size_t size_q;
    logic         sign_q;
    logic [31:0]  addr_q;
    logic [31:0]  wdata_q;
    logic         timer_q;

    logic         accept;
    logic         req_timer;
    logic         drop_wr;
    logic         addr_ack;
    logic         resp_ack;
    logic [1:0]   resp_code;
    logic         resp_err;
    logic [31:0]  bus_rdata;
    logic [2:0]   axsize;
    logic [31:0]  load_data;

    assign ready  = (state == st_idle) || (state == st_done);
    assign done   = (state == st_done);
    assign accept = req && ready;

    // timer window decode, done once on the incoming address
    assign req_timer = (addr >= CLINT_BASE) && (addr <= CLINT_END);

    // timer is read only, writes there never reach a bus
    assign drop_wr = wen_q && timer_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            wen_q   <= wen;
            size_q  <= size;
            sign_q  <= sign;
            addr_q  <= addr;
            wdata_q <= wdata;
            timer_q <= req_timer;
        end
    end

    lsu_align u_lsu_align (
        .size        (size_q),
        .sign        (sign_q),
        .addr_low    (addr_q[1:0]),
        .wdata       (wdata_q),
        .bus_rdata   (bus_rdata),
        .wstrb       (wstrb),
        .axsize      (axsize),
        .wdata_lanes (wdata_o),
        .load_data   (load_data)
    );

    // steer handshakes to whichever slave owns the access
    assign addr_ack  = wen_q ? awready : (timer_q ? t_arready : arready);
    assign resp_ack  = wen_q ? bvalid : (timer_q ? t_rvalid : rvalid);
    assign resp_code = wen_q ? bresp : (timer_q ? t_rresp : rresp);
    assign bus_rdata = timer_q ? t_rdata : rdata_i;

    // a main-memory read must come back as the last beat
    assign resp_err = (resp_code != RESP_OKAY) || (!wen_q && !timer_q && !rlast);

    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_done: begin
                if (!accept) begin
                    state_next = st_idle;
                end else if (wen && req_timer) begin
                    state_next = st_resp;
                end else begin
                    state_next = st_addr;
                end
            end
            st_addr: begin
                if (addr_ack) begin
                    state_next = wen_q ? st_data : st_resp;
                end
            end
            st_data: begin
                if (wready) begin
                    state_next = st_resp;
                end
            end
            st_resp: begin
                if (drop_wr || resp_ack) begin
                    state_next = st_done;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            err   <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_resp) begin
                if (drop_wr) begin
                    err <= 1'b1;
                end else if (resp_ack) begin
                    err <= resp_err;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_resp && resp_ack && !wen_q) begin
            rdata <= load_data;
        end
    end

    // channel outputs follow the state
    assign awvalid   = (state == st_addr) && wen_q;
    assign awaddr    = addr_q;
    assign awsize    = axsize;
    assign wvalid    = (state == st_data);
    assign wlast     = wvalid;
    assign bready    = 1'b1;
    assign arvalid   = (state == st_addr) && !wen_q && !timer_q;
    assign araddr    = addr_q;
    assign arsize    = axsize;
    assign rready    = 1'b1;
    assign t_arvalid = (state == st_addr) && !wen_q && timer_q;
    assign t_araddr  = addr_q;

endmodule

// File: lsu/lsu_align.sv
`timescale 1ns/1ps

module lsu_align import lsu_pkg::*; (
    input  access_size_t size,
    input  logic         sign,
    input  logic [1:0]   addr_low,
    input  logic [31:0]  wdata,
    input  logic [31:0]  bus_rdata,
    output logic [3:0]   wstrb,
    output logic [2:0]   axsize,
    output logic [31:0]  wdata_lanes,
    output logic [31:0]  load_data
);

    logic [4:0]  lane_shift;
    logic [31:0] rd_shifted;

    assign lane_shift = {addr_low, 3'b000};

    // strobe and axi size from the access width
    always_comb begin
        case (size)
            size_byte: begin
                wstrb  = 4'b0001 << addr_low;
                axsize = 3'd0;
            end
            size_half: begin
                wstrb  = addr_low[1] ? 4'b1100 : 4'b0011;
                axsize = 3'd1;
            end
            size_word: begin
                wstrb  = 4'b1111;
                axsize = 3'd2;
            end
            default: begin
                wstrb  = 4'b0000;
                axsize = 3'd0;
            end
        endcase
    end

    // store data moves up into its byte lane
    assign wdata_lanes = wdata << lane_shift;

    // read data comes down to bit 0, then gets extended
    assign rd_shifted = bus_rdata >> lane_shift;

    always_comb begin
        case (size)
            size_byte: load_data = {{24{sign & rd_shifted[7]}}, rd_shifted[7:0]};
            size_half: load_data = {{16{sign & rd_shifted[15]}}, rd_shifted[15:0]};
            size_word: load_data = rd_shifted;
            default:   load_data = 32'h0;
        endcase
    end

endmodule
